// ==== src.f ====
+incdir+source
source/icd2_pkg.sv
source/icd2_regs.sv
source/pixel_packer.sv
source/row_buffers.sv
source/joypad_serial.sv
source/icd2_top.sv
verification/icd2_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the icd2 testbench with verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module icd2_tb -o icd2_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_out="$(./obj_dir/icd2_sim 2>&1)"
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qF '*** PASSED ***'; then
  exit 0
fi
exit 1

// ==== verification/icd2_tb.sv ====
`include "icd2_defs.svh"

module icd2_tb;
  import icd2_pkg::*;

  // pixel test is 1601 dots x 4 cycles, the rest stays under 3k cycles
  localparam int MAX_CYCLES = 200000;
  localparam int K_BYTE     = 0;        // data_out
  localparam int K_P1       = 1;        // p1_out
  localparam int K_IDLE     = 2;
  localparam int K_GBRST    = 3;

  logic         CLK;
  logic         cpu_ireset_r;
  logic         snes_rd_start;
  logic         snes_wr_end;
  logic [23:0]  snes_addr;
  logic [7:0]   data_in;
  logic [7:0]   data_out;
  logic         ppu_dot_edge;
  logic         ppu_pixel_valid;
  logic [1:0]   ppu_pixel;
  logic         ppu_vsync_edge;
  logic         cpu_edge;
  logic [1:0]   p1_in;
  logic [3:0]   p1_out;
  logic         idle;
  logic         gb_reset;

  logic         cmp_req;               // one cycle request to the compare process
  int           cmp_kind;
  string        cmp_name;
  logic [7:0]   cmp_exp;
  int           cycle_cnt = 0;
  int           i;
  int           k;
  logic [31:0]  rnd;
  pad_bank_t    pad_val;               // pads as written over the bus
  logic [1:0]   id_exp;
  logic [127:0] pkt_bits;
  logic [1:0]   pix_mem [8][160];      // dots of the 8 lines, [line][x]
  lcdc_u        lcdc_exp;

  icd2_top i_icd2_top (.*);

  always #5 CLK = ~CLK;

  // ---------------------------------------------------------------------------
  // reference model
  // ---------------------------------------------------------------------------
  function automatic logic [3:0] p1_ref(input pad_bank_t pads, input logic [1:0] id,
                                        input logic [1:0] sel);
    case (sel)
      2'b11:   return {2'b11, ~id};                     // inverted pad id
      2'b01:   return pads[id][7:4];                    // bit 1 low, d-pad
      2'b10:   return pads[id][3:0];                    // bit 0 low, buttons
      default: return pads[id][7:4] & pads[id][3:0];
    endcase
  endfunction

  // packet bit k lands in byte k/8, bit k%8
  function automatic logic [7:0] pkt_byte(input logic [127:0] bits, input int idx);
    return bits[idx*8 +: 8];
  endfunction

  // row byte address is col*16 + line*2 + plane, pixel n of a group at bit 7-n
  function automatic logic [7:0] planar_byte(input int addr);
    int         col;
    int         line;
    int         plane;
    logic [7:0] b;
    col   = addr / 16;
    line  = (addr / 2) % 8;
    plane = addr % 2;
    for (int n = 0; n < 8; n++) begin
      b[7-n] = pix_mem[line][col*8+n][plane];
    end
    return b;
  endfunction

  // ---------------------------------------------------------------------------
  // checks
  // ---------------------------------------------------------------------------
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("*** FAILED ***");
    $fatal(1, "run stopped");
  endtask

  task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp) abort_run($sformatf("error %s: expected %02h, actual %02h", name, exp, act));
  endtask

  task automatic check_p1(input string name, input logic [3:0] exp, input logic [3:0] act);
    if (act !== exp) abort_run($sformatf("error %s: expected %01h, actual %01h", name, exp, act));
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) abort_run($sformatf("error %s: expected %b, actual %b", name, exp, act));
  endtask

  // sampled mid cycle, all dut outputs settled
  always @(negedge CLK) begin
    if (cmp_req) begin
      case (cmp_kind)
        K_BYTE:  check_byte(cmp_name, cmp_exp, data_out);
        K_P1:    check_p1(cmp_name, cmp_exp[3:0], p1_out);
        K_IDLE:  check_bit(cmp_name, cmp_exp[0], idle);
        default: check_bit(cmp_name, cmp_exp[0], gb_reset);
      endcase
    end
  end

  always @(posedge CLK) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) abort_run($sformatf("timeout, run hung past %0d cycles",
                                                     MAX_CYCLES));
  end

  // ---------------------------------------------------------------------------
  // stimulus tasks, all entered 1 unit after a rising edge
  // ---------------------------------------------------------------------------
  task automatic expect_result(input int kind, input string name, input logic [7:0] exp);
    cmp_kind = kind;
    cmp_name = name;
    cmp_exp  = exp;
    cmp_req  = 1'b1;
    @(posedge CLK);
    #1;
    cmp_req  = 1'b0;
  endtask

  // 4 cycles per access, enough for the char data pipe to refill
  task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
    snes_addr   = {8'h00, addr};
    data_in     = data;
    snes_wr_end = 1'b1;
    @(posedge CLK);
    #1;
    snes_wr_end = 1'b0;
    repeat (3) @(posedge CLK);
    #1;
  endtask

  task automatic bus_read(input logic [15:0] addr, input string name, input logic [7:0] exp);
    snes_addr     = {8'h00, addr};
    snes_rd_start = 1'b1;
    @(posedge CLK);
    #1;
    snes_rd_start = 1'b0;
    repeat (2) @(posedge CLK);
    #1;
    expect_result(K_BYTE, name, exp);
  endtask

  task automatic p1_step(input logic [1:0] val);
    p1_in    = val;
    cpu_edge = 1'b1;
    @(posedge CLK);
    #1;
    cpu_edge = 1'b0;
  endtask

  task automatic send_dot(input logic valid, input logic [1:0] pix, input logic vsync);
    ppu_dot_edge    = 1'b1;
    ppu_pixel_valid = valid;
    ppu_pixel       = pix;
    ppu_vsync_edge  = vsync;
    @(posedge CLK);
    #1;
    ppu_dot_edge    = 1'b0;
    ppu_pixel_valid = 1'b0;
    ppu_vsync_edge  = 1'b0;
    repeat (3) @(posedge CLK);                   // one dot every 4 cycles
    #1;
  endtask

  initial begin
    rnd             = $urandom(90851);
    CLK             = 1'b0;
    cpu_ireset_r    = 1'b1;
    snes_rd_start   = 1'b0;
    snes_wr_end     = 1'b0;
    snes_addr       = 24'h000000;
    data_in         = 8'h00;
    ppu_dot_edge    = 1'b0;
    ppu_pixel_valid = 1'b0;
    ppu_pixel       = 2'b00;
    ppu_vsync_edge  = 1'b0;
    cpu_edge        = 1'b0;
    p1_in           = 2'b11;
    cmp_req         = 1'b0;
    repeat (8) @(posedge CLK);
    #1;
    cpu_ireset_r    = 1'b0;

    // after reset
    expect_result(K_BYTE, "data_out reset", 8'h00);
    expect_result(K_GBRST, "gb_reset reset", 8'h01);
    expect_result(K_IDLE, "idle reset", 8'h01);
    expect_result(K_P1, "p1 id reset", 8'h0F);
    bus_read(`ADDR_VER, "version", `ICD2_VERSION);
    bus_read(`ADDR_PKTRDY, "pktrdy reset", 8'h00);
    p1_step(2'b11);                              // one player, id masked to 0
    expect_result(K_P1, "p1 id one player", 8'h0F);

    // pads, 4 players
    bus_write(`ADDR_CTL, 8'hB0);
    expect_result(K_GBRST, "gb_reset run", 8'h00);
    for (i = 0; i < 4; i++) begin
      rnd        = $urandom();
      pad_val[i] = rnd[7:0];
      bus_write(`ADDR_PAD0 + 16'(i), rnd[7:0]);
    end
    id_exp = 2'd0;
    for (i = 0; i < 8; i++) begin
      p1_step(2'b01);
      expect_result(K_P1, "p1 dpad", {4'h0, p1_ref(pad_val, id_exp, 2'b01)});
      p1_step(2'b11);
      id_exp = id_exp + 2'd1;                    // 01 -> 11 steps the id
      expect_result(K_P1, "p1 id", {4'h0, p1_ref(pad_val, id_exp, 2'b11)});
      p1_step(2'b10);
      expect_result(K_P1, "p1 buttons", {4'h0, p1_ref(pad_val, id_exp, 2'b10)});
      p1_step(2'b11);
    end

    // serial packet, 11 between bits
    for (i = 0; i < 4; i++) begin
      pkt_bits[i*32 +: 32] = $urandom();
    end
    p1_step(2'b00);
    p1_step(2'b11);
    for (k = 0; k < `PKT_BITS; k++) begin
      p1_step(pkt_bits[k] ? 2'b01 : 2'b10);
      p1_step(2'b11);
    end
    p1_step(2'b10);                              // terminator
    expect_result(K_IDLE, "idle after packet", 8'h01);
    bus_read(`ADDR_PKTRDY, "pktrdy set", 8'h01);
    for (i = 0; i < `PKT_CNT; i++) begin
      bus_read(`ADDR_PKT + 16'(i), $sformatf("pkt byte %0d", i), pkt_byte(pkt_bits, i));
    end
    bus_read(`ADDR_PKTRDY, "pktrdy ack", 8'h00);

    // abort, 10 while waiting for the next bit
    p1_step(2'b11);
    p1_step(2'b00);
    p1_step(2'b11);
    p1_step(2'b01);
    expect_result(K_IDLE, "idle mid packet", 8'h00);
    p1_step(2'b10);
    expect_result(K_IDLE, "idle after abort", 8'h01);
    bus_read(`ADDR_PKTRDY, "pktrdy after abort", 8'h00);

    // pixels, 8 lines fill char row 0 in row buffer 0
    send_dot(1'b0, 2'b00, 1'b1);
    for (k = 0; k < 8; k++) begin
      for (i = 0; i < 160; i++) begin
        rnd           = $urandom();
        pix_mem[k][i] = rnd[1:0];
        send_dot(1'b1, rnd[1:0], 1'b0);
      end
      repeat (40) send_dot(1'b0, 2'b00, 1'b0); // hblank
    end
    lcdc_exp             = '0;
    lcdc_exp.f.char_row  = 5'd1;
    lcdc_exp.f.row_index = 2'd1;
    bus_read(`ADDR_LCDCHW, "lcd status", lcdc_exp.raw);
    bus_write(`ADDR_LCDCHR, 8'h00);
    for (i = 0; i < `ROW_BYTES; i++) begin
      bus_read(`ADDR_CHDAT, $sformatf("row byte %0d", i), planar_byte(i));
    end

    $display("*** PASSED ***");
    $finish;
  end

endmodule

// ==== source/icd2_top.sv ====
`include "icd2_defs.svh"

module icd2_top (
  input  logic        CLK,
  input  logic        cpu_ireset_r,
  // cartridge bus
  input  logic        snes_rd_start,
  input  logic        snes_wr_end,
  input  logic [23:0] snes_addr,
  input  logic [7:0]  data_in,
  output logic [7:0]  data_out,
  // ppu dot stream
  input  logic        ppu_dot_edge,
  input  logic        ppu_pixel_valid,
  input  logic [1:0]  ppu_pixel,
  input  logic        ppu_vsync_edge,
  // game boy side
  input  logic        cpu_edge,
  input  logic [1:0]  p1_in,
  output logic [3:0]  p1_out,
  output logic        idle,
  output logic        gb_reset
);
  import icd2_pkg::*;

  lcdc_u                  lcdc;          // packer -> regs
  pad_bank_t              pads;          // regs -> joypad
  pkt_index_t             pkt_sel;
  logic [1:0]             players;
  logic                   pktrdy_clear;
  logic [7:0]             pkt_data;      // joypad -> regs
  logic                   pktrdy;
  logic                   wr_en;         // packer -> row buffers
  logic [1:0]             wr_row;
  logic [`ROW_ADDR_W-1:0] wr_addr;
  logic [7:0]             wr_data;
  logic [1:0]             rd_row;        // regs <-> row buffers
  logic [`ROW_ADDR_W-1:0] rd_addr;
  logic [7:0]             rd_data;

  icd2_regs u_regs (
    .CLK, .cpu_ireset_r, .snes_rd_start, .snes_wr_end, .snes_addr, .data_in,
    .lcdc, .pkt_data, .pktrdy, .rd_data, .data_out, .gb_reset, .players,
    .pads, .pkt_sel, .pktrdy_clear, .rd_row, .rd_addr
  );

  pixel_packer u_packer (
    .CLK, .cpu_ireset_r, .ppu_dot_edge, .ppu_pixel_valid, .ppu_pixel,
    .ppu_vsync_edge, .lcdc, .wr_en, .wr_row, .wr_addr, .wr_data
  );

  row_buffers u_rows (
    .CLK, .wr_en, .wr_row, .wr_addr, .wr_data, .rd_row, .rd_addr, .rd_data
  );

  joypad_serial u_joy (
    .CLK, .cpu_ireset_r, .cpu_edge, .p1_in, .pads, .players, .pkt_sel,
    .pktrdy_clear, .p1_out, .idle, .pkt_data, .pktrdy
  );

endmodule

// ==== source/joypad_serial.sv ====
`include "icd2_defs.svh"

module joypad_serial (
  input  logic                 CLK,
  input  logic                 cpu_ireset_r,
  input  logic                 cpu_edge,      // p1_in is sampled only here
  input  logic [1:0]           p1_in,
  input  icd2_pkg::pad_bank_t  pads,
  input  logic [1:0]           players,
  input  icd2_pkg::pkt_index_t pkt_sel,
  input  logic                 pktrdy_clear,
  output logic [3:0]           p1_out,
  output logic                 idle,
  output logic [7:0]           pkt_data,
  output logic                 pktrdy
);
  import icd2_pkg::*;

  localparam int BIT_POS_W = $clog2(`PKT_BITS);

  btn_state_e           state_r;
  btn_state_e           next_r;      // state to take on the next 11
  logic [1:0]           prev_r;      // p1_in at the last cpu edge
  logic [1:0]           id_r;        // current pad id
  logic [BIT_POS_W-1:0] bit_pos_r;
  logic [7:0]           pkt_r [`PKT_CNT];
  logic                 pktrdy_set_r;

  // -------------------------------------------------------------------------
  // p1 output
  // -------------------------------------------------------------------------
  // 11 -> ~id, 01 -> pad[7:4], 10 -> pad[3:0], 00 -> both anded
  assign p1_out = (&p1_in) ? ~{2'b00, id_r}
                : (({4{p1_in[1]}} | pads[id_r][7:4]) & ({4{p1_in[0]}} | pads[id_r][3:0]));

  // gb may run while waiting for the first bit
  assign idle = (state_r == IDLE) || (state_r == WAIT && bit_pos_r == '0);

  assign pkt_data = pkt_r[pkt_sel];

  // -------------------------------------------------------------------------
  // port fsm
  // -------------------------------------------------------------------------
  always_ff @(posedge CLK) begin
    if (cpu_ireset_r) begin
      state_r      <= IDLE;
      next_r       <= IDLE;
      prev_r       <= 2'b00;
      id_r         <= 2'd0;
      bit_pos_r    <= '0;
      pktrdy_set_r <= 1'b0;
    end else begin
      pktrdy_set_r <= 1'b0;
      if (cpu_edge) begin
        prev_r <= p1_in;
        if (p1_in != prev_r) begin
          if (p1_in == 2'b00) begin
            // a move to 00 from anywhere starts a packet
            bit_pos_r <= '0;
            next_r    <= RECV;
            state_r   <= WAIT;
          end else begin
            case (state_r)
              IDLE: begin
                if (~prev_r[1] && p1_in[1]) begin
                  id_r <= (id_r + 1'b1) & players;  // wraps at player count
                end
              end
              RECV: begin
                if (^p1_in) begin                   // 11 is a nop here
                  bit_pos_r <= bit_pos_r + 1'b1;
                  next_r    <= (&bit_pos_r) ? WAIT : RECV;  // last bit, wait for term
                  state_r   <= WAIT;
                end
              end
              WAIT: begin
                // 11 between bits, 10 as the terminator
                if (p1_in == {1'b1, next_r != IDLE}) begin
                  pktrdy_set_r <= (next_r == IDLE);
                  next_r       <= IDLE;
                  state_r      <= next_r;
                end else if (^p1_in) begin
                  state_r <= IDLE;                  // bad transition, abort
                end
              end
              END: state_r <= IDLE;                 // not entered by the protocol
              default: state_r <= IDLE;
            endcase
          end
        end
      end
    end
  end

  // packet bits, lsb first within each byte
  always_ff @(posedge CLK) begin
    if (cpu_edge && p1_in != prev_r && state_r == RECV && ^p1_in) begin
      pkt_r[bit_pos_r[BIT_POS_W-1:3]][bit_pos_r[2:0]] <= p1_in[0];
    end
  end

  always_ff @(posedge CLK) begin
    if (cpu_ireset_r) begin
      pktrdy <= 1'b0;
    end else begin
      pktrdy <= (pktrdy & ~pktrdy_clear) | pktrdy_set_r;  // set wins over ack
    end
  end

  a_state_onehot: assert property (@(posedge CLK) disable iff (cpu_ireset_r)
    $onehot(state_r));

endmodule

// ==== source/row_buffers.sv ====
`include "icd2_defs.svh"

module row_buffers (
  input  logic                   CLK,
  input  logic                   wr_en,
  input  logic [1:0]             wr_row,
  input  logic [`ROW_ADDR_W-1:0] wr_addr,
  input  logic [7:0]             wr_data,
  input  logic [1:0]             rd_row,
  input  logic [`ROW_ADDR_W-1:0] rd_addr,
  output logic [7:0]             rd_data
);

  logic [7:0] rd_q [`ROW_CNT];  // registered read port of each buffer
  logic [1:0] rd_row_q;

  // one simple dual port ram per scanline row
  for (genvar r = 0; r < `ROW_CNT; r++) begin : g_row
    logic [7:0] mem [`ROW_BYTES];

    always_ff @(posedge CLK) begin
      if (wr_en && wr_row == r) begin  // packer writes only its current row
        mem[wr_addr] <= wr_data;
      end
      rd_q[r] <= mem[rd_addr];
    end
  end

  // row select follows the read address by one cycle
  always_ff @(posedge CLK) begin
    rd_row_q <= rd_row;
  end

  assign rd_data = rd_q[rd_row_q];

endmodule

// ==== source/pixel_packer.sv ====
`include "icd2_defs.svh"

module pixel_packer (
  input  logic                   CLK,
  input  logic                   cpu_ireset_r,
  input  logic                   ppu_dot_edge,     // qualifies the other ppu inputs
  input  logic                   ppu_pixel_valid,
  input  logic [1:0]             ppu_pixel,
  input  logic                   ppu_vsync_edge,
  output icd2_pkg::lcdc_u        lcdc,
  output logic                   wr_en,
  output logic [1:0]             wr_row,
  output logic [`ROW_ADDR_W-1:0] wr_addr,
  output logic [7:0]             wr_data
);

  logic [4:0] col_r;       // tile column, 0..20
  logic [2:0] line_r;      // line within the tile
  logic [2:0] pix_idx_r;   // pixel within the group of 8
  logic [7:0] plane_r [2]; // planar bytes being built
  logic [1:0] wr_pend_r;   // [0] plane 0 due next, [1] plane 1 due
  logic [7:0] wr_base_r;   // {col, line} of the finished group

  // byte address is {col, line, plane}
  assign wr_en   = |wr_pend_r;
  assign wr_row  = lcdc.f.row_index;
  assign wr_addr = {wr_base_r, wr_pend_r[1]};
  assign wr_data = plane_r[wr_pend_r[1]];

  // -------------------------------------------------------------------------
  // counters
  // -------------------------------------------------------------------------
  always_ff @(posedge CLK) begin
    if (cpu_ireset_r) begin
      lcdc      <= '0;
      col_r     <= 5'd0;
      line_r    <= 3'd0;
      pix_idx_r <= 3'd0;
      wr_pend_r <= 2'b00;
    end else begin
      wr_pend_r <= {wr_pend_r[0], 1'b0};
      if (ppu_dot_edge) begin
        if (ppu_pixel_valid) begin
          pix_idx_r <= pix_idx_r + 1'b1;
          if (&pix_idx_r) begin           // 8th pixel, group done
            col_r        <= col_r + 1'b1;
            wr_pend_r[0] <= 1'b1;
          end
        end else if (ppu_vsync_edge) begin
          col_r           <= 5'd0;        // new frame
          pix_idx_r       <= 3'd0;
          lcdc.f.char_row <= 5'd0;
        end else if (col_r == 5'd20 && lcdc.f.char_row < 5'd18) begin
          // first blank dot after pixel 159 closes the line
          col_r  <= 5'd0;
          line_r <= line_r + 1'b1;
          if (line_r == 3'd7) begin
            lcdc.f.row_index <= lcdc.f.row_index + 1'b1;  // next row buffer
            lcdc.f.char_row  <= lcdc.f.char_row + 1'b1;
          end
        end
      end
    end
  end

  // pixel n lands in bit 7-n, high bit to plane 1
  always_ff @(posedge CLK) begin
    if (ppu_dot_edge && ppu_pixel_valid) begin
      plane_r[1][~pix_idx_r] <= ppu_pixel[1];
      plane_r[0][~pix_idx_r] <= ppu_pixel[0];
      if (&pix_idx_r) begin
        wr_base_r <= {col_r, line_r};
      end
    end
  end

  // the column stops at 20, so every byte written stays in the scanline
  a_wr_addr_range: assert property (@(posedge CLK) disable iff (cpu_ireset_r)
    wr_en |-> (wr_addr < `ROW_BYTES));

endmodule

// ==== source/icd2_regs.sv ====
`include "icd2_defs.svh"

module icd2_regs (
  input  logic                   CLK,
  input  logic                   cpu_ireset_r,
  input  logic                   snes_rd_start,  // one cycle, start of bus read
  input  logic                   snes_wr_end,    // one cycle, end of bus write
  input  logic [23:0]            snes_addr,
  input  logic [7:0]             data_in,
  input  icd2_pkg::lcdc_u        lcdc,
  input  logic [7:0]             pkt_data,
  input  logic                   pktrdy,
  input  logic [7:0]             rd_data,
  output logic [7:0]             data_out,
  output logic                   gb_reset,
  output logic [1:0]             players,
  output icd2_pkg::pad_bank_t    pads,
  output icd2_pkg::pkt_index_t   pkt_sel,
  output logic                   pktrdy_clear,
  output logic [1:0]             rd_row,
  output logic [`ROW_ADDR_W-1:0] rd_addr
);

  // -------------------------------------------------------------------------
  // address decode
  // -------------------------------------------------------------------------
  logic [15:0] reg_key;
  logic        bus_hit;
  logic        sel_lcdchw, sel_lcdchr, sel_pktrdy, sel_ctl;
  logic        sel_pad, sel_ver, sel_pkt, sel_chdat;

  logic [7:0]  ctl_r;    // [7] run, [5:4] players, rest not kept
  logic [7:0]  chdat_r;  // row byte at the read pointer

  // only a15:11 and a3:0 take part in the decode
  assign reg_key = {snes_addr[15:11], 7'h00, snes_addr[3:0]};
  assign bus_hit = ~snes_addr[22];

  assign sel_lcdchw = bus_hit && (reg_key == `ADDR_LCDCHW);
  assign sel_lcdchr = bus_hit && (reg_key == `ADDR_LCDCHR);
  assign sel_pktrdy = bus_hit && (reg_key == `ADDR_PKTRDY);
  assign sel_ctl    = bus_hit && (reg_key == `ADDR_CTL);
  assign sel_pad    = bus_hit && ({reg_key[15:2], 2'b00} == `ADDR_PAD0);  // 4 pads
  assign sel_ver    = bus_hit && (reg_key == `ADDR_VER);
  assign sel_pkt    = bus_hit && ({reg_key[15:4], 4'h0} == `ADDR_PKT);    // 16 bytes
  assign sel_chdat  = bus_hit && (reg_key == `ADDR_CHDAT);

  assign pkt_sel  = snes_addr[3:0];  // packet byte comes back combinationally
  assign gb_reset = ~ctl_r[7];
  assign players  = ctl_r[5:4];

  // -------------------------------------------------------------------------
  // read data, control and pads
  // -------------------------------------------------------------------------
  always_ff @(posedge CLK) begin
    if (cpu_ireset_r) begin
      data_out     <= 8'h00;
      ctl_r        <= `CTL_RESET;
      pads         <= {4{8'hFF}};  // nothing pressed
      rd_row       <= 2'd0;
      rd_addr      <= '0;
      pktrdy_clear <= 1'b0;
    end else begin
      pktrdy_clear <= 1'b0;

      // flop read data at the start of the bus cycle so it holds steady
      if (snes_rd_start) begin
        if (sel_lcdchw) begin
          data_out <= lcdc.raw;
        end else if (sel_pktrdy) begin
          data_out <= {7'h00, pktrdy};
        end else if (sel_ver) begin
          data_out <= `ICD2_VERSION;
        end else if (sel_pkt) begin
          data_out     <= pkt_data;
          pktrdy_clear <= (snes_addr[3:0] == 4'h0);  // first byte acks the packet
        end else if (sel_chdat) begin
          data_out <= chdat_r;
          rd_addr  <= rd_addr + 1'b1;                // walk the row buffer
        end
      end

      if (snes_wr_end) begin
        if (sel_lcdchr) begin
          rd_row  <= data_in[1:0];  // pick row, restart pointer
          rd_addr <= '0;
        end else if (sel_ctl) begin
          ctl_r <= {data_in[7], 1'b0, data_in[5:4], 4'h0};
        end else if (sel_pad) begin
          pads[snes_addr[1:0]] <= data_in;
        end
      end

      // pads of disabled players read as released
      case (ctl_r[5:4])
        2'd0: begin
          pads[1] <= 8'hFF;
          pads[2] <= 8'hFF;
          pads[3] <= 8'hFF;
        end
        2'd1: begin
          pads[2] <= 8'hFF;
          pads[3] <= 8'hFF;
        end
        default: ;  // 3 keeps all, 2 is not a valid setting
      endcase
    end
  end

  // second stage of the char data pipe, ram output -> chdat
  always_ff @(posedge CLK) begin
    chdat_r <= rd_data;
  end

endmodule

// ==== source/icd2_pkg.sv ====
`include "icd2_defs.svh"

package icd2_pkg;

  // lcd status byte, read raw over the bus, counted by fields in the packer
  typedef union packed {
    logic [7:0] raw;
    struct packed {
      logic [4:0] char_row;   // char row of the ppu, 0..17
      logic       spare;
      logic [1:0] row_index;  // row buffer being written
    } f;
  } lcdc_u;

  // four pad bytes, byte n at [n]
  typedef logic [3:0][7:0] pad_bank_t;

  // packet byte select
  typedef logic [$clog2(`PKT_CNT)-1:0] pkt_index_t;

  // joypad port fsm, one-hot
  typedef enum logic [3:0] {
    IDLE = 4'b0001,
    RECV = 4'b0010,
    WAIT = 4'b0100,
    END  = 4'b1000
  } btn_state_e;

endpackage

// ==== source/icd2_defs.svh ====
`ifndef ICD2_DEFS_SVH
`define ICD2_DEFS_SVH

// row buffer geometry
`define ROW_CNT      4       // scanline buffers, one per char row in flight
`define ROW_ADDR_W   9
`define ROW_BYTES    320     // 20 tiles x 8 lines x 2 planes

// serial packet
`define PKT_CNT      16
`define PKT_BITS     128

// fixed register values
`define ICD2_VERSION 8'h61
`define CTL_RESET    8'h01   // gb held in reset, 1 player

// ---------------------------------------------------------------------------
// register keys, matched with snes_addr[22] clear
// ---------------------------------------------------------------------------
`define ADDR_LCDCHW  16'h6000  // R lcd status
`define ADDR_LCDCHR  16'h6001  // W row select
`define ADDR_PKTRDY  16'h6002  // R packet ready
`define ADDR_CTL     16'h6003  // W control
`define ADDR_PAD0    16'h6004  // W pads, 6004-6007
`define ADDR_VER     16'h600F  // R version
`define ADDR_PKT     16'h7000  // R packet bytes, 7000-700F
`define ADDR_CHDAT   16'h7800  // R character data

`endif
